//--- run.sh
#!/bin/sh
# build with Verilator, run, and judge the run from its log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal -f vlog.f --top-module border_crop_tb \
    -o border_crop_sim > build.log 2>&1 || { cat build.log; echo "build error"; exit 1; }
./obj_dir/border_crop_sim > sim.log 2>&1
cat sim.log
grep -q "test failed" sim.log && exit 1
grep -q "test passed" sim.log || exit 1
exit 0

//--- src/border_crop_config.svh
`ifndef BORDER_CROP_CONFIG_SVH
`define BORDER_CROP_CONFIG_SVH

// pixel word width
`define PEL_W 8

// header words and row/col counters share one width
`define SIZE_W 7

// number of independent streams sharing the decision path
`define NUM_STREAMS 2

// tag width, log2 of the stream count but never below 1
`define TAG_W 1

// leading rows discarded at the top of every frame
`define DROP_ROWS 7

`endif

//--- src/border_crop_pkg.sv
`include "border_crop_config.svh"

package border_crop_pkg;

    // per stream frame phase
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        DROP = 2'd1,
        WORK = 2'd2
    } crop_state_e;

    // everything the shared path needs to resume a stream
    typedef struct packed {
        crop_state_e         state;
        logic [`SIZE_W-1:0]  col;
        logic [`SIZE_W-1:0]  row;
        logic [`SIZE_W-1:0]  width;
        logic [`SIZE_W-1:0]  height;
    } frame_ctx_t;

    // result of one stream's decision for the current cycle
    typedef struct packed {
        logic        active;
        logic        rd_pel;
        logic        rd_hdr;
        logic        wr;
        frame_ctx_t  nxt_ctx;
    } crop_step_t;

    // word pushed to the output side, tag picks the stream FIFO
    typedef struct packed {
        logic [`TAG_W-1:0]  tag;
        logic [`PEL_W-1:0]  pel;
    } out_pel_t;

endpackage

//--- src/border_crop_top.sv
`timescale 1ns/1ps
`include "border_crop_config.svh"

module border_crop_top
    import border_crop_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,

    // pixel input FIFOs, first word fall through
    input  logic [`NUM_STREAMS-1:0]  in_pel_empty,
    input  logic [`PEL_W-1:0]        in_pel_data  [`NUM_STREAMS],
    output logic [`NUM_STREAMS-1:0]  in_pel_read,

    // header FIFOs
    input  logic [`NUM_STREAMS-1:0]  height_empty,
    input  logic [`SIZE_W-1:0]       height_data  [`NUM_STREAMS],
    output logic [`NUM_STREAMS-1:0]  height_read,
    input  logic [`NUM_STREAMS-1:0]  width_empty,
    input  logic [`SIZE_W-1:0]       width_data   [`NUM_STREAMS],
    output logic [`NUM_STREAMS-1:0]  width_read,

    // output FIFOs, one write port shared through the tag
    input  logic [`NUM_STREAMS-1:0]  out_full,
    output logic                     out_write,
    output out_pel_t                 out_pel
);

    frame_ctx_t         ctx   [`NUM_STREAMS];
    crop_step_t         steps [`NUM_STREAMS];
    logic               upd_en;
    logic [`TAG_W-1:0]  upd_tag;
    frame_ctx_t         upd_ctx;

    // one decision per stream, all evaluated every cycle
    for (genvar s = 0; s < `NUM_STREAMS; s++)
    begin : g_step
        crop_step i_crop_step (
            .ctx          (ctx[s]),
            .pel_empty    (in_pel_empty[s]),
            .height_empty (height_empty[s]),
            .width_empty  (width_empty[s]),
            .out_full     (out_full[s]),
            .step         (steps[s])
        );
    end

    stream_arbiter i_stream_arbiter (
        .steps       (steps),
        .in_pel_data (in_pel_data),
        .height_data (height_data),
        .width_data  (width_data),
        .in_pel_read (in_pel_read),
        .height_read (height_read),
        .width_read  (width_read),
        .out_write   (out_write),
        .out_pel     (out_pel),
        .upd_en      (upd_en),
        .upd_tag     (upd_tag),
        .upd_ctx     (upd_ctx)
    );

    // context of the served stream lands at the next edge
    frame_ctx_regs i_frame_ctx_regs (
        .clk     (clk),
        .rst     (rst),
        .upd_en  (upd_en),
        .upd_tag (upd_tag),
        .upd_ctx (upd_ctx),
        .ctx     (ctx)
    );

endmodule

//--- src/crop_step.sv
`timescale 1ns/1ps
`include "border_crop_config.svh"

module crop_step
    import border_crop_pkg::*;
(
    input  frame_ctx_t  ctx,
    input  logic        pel_empty,
    input  logic        height_empty,
    input  logic        width_empty,
    input  logic        out_full,
    output crop_step_t  step
);

    // row index of the last discarded row
    localparam logic [`SIZE_W-1:0] LAST_DROP_ROW = `SIZE_W'(`DROP_ROWS - 1);

    logic               col_last;
    logic               row_last;
    logic [`SIZE_W-1:0] col_inc;
    logic [`SIZE_W-1:0] row_inc;

    assign col_last = (ctx.col == ctx.width - 1'b1);
    assign row_last = (ctx.row == ctx.height - 1'b1);
    assign col_inc  = ctx.col + 1'b1;
    assign row_inc  = ctx.row + 1'b1;

    always_comb
    begin
        step         = '0;
        step.nxt_ctx = ctx;

        case (ctx.state)
            IDLE:
            begin
                // both header words must be there, they are popped together
                if (!height_empty && !width_empty)
                begin
                    step.active        = 1'b1;
                    step.rd_hdr        = 1'b1;
                    step.nxt_ctx.state = DROP;
                    step.nxt_ctx.col   = '0;
                    step.nxt_ctx.row   = '0;
                end
            end

            DROP:
            begin
                // discard, no output space needed
                if (!pel_empty)
                begin
                    step.active = 1'b1;
                    step.rd_pel = 1'b1;
                    if (col_last)
                    begin
                        step.nxt_ctx.col = '0;
                        step.nxt_ctx.row = row_inc;
                        if (ctx.row == LAST_DROP_ROW)
                        begin
                            step.nxt_ctx.state = WORK;
                        end
                    end
                    else
                    begin
                        step.nxt_ctx.col = col_inc;
                    end
                end
            end

            WORK:
            begin
                // forward only when the pixel can be written this cycle
                if (!pel_empty && !out_full)
                begin
                    step.active = 1'b1;
                    step.rd_pel = 1'b1;
                    step.wr     = 1'b1;
                    if (col_last && row_last)
                    begin
                        step.nxt_ctx.state = IDLE;
                        step.nxt_ctx.col   = '0;
                        step.nxt_ctx.row   = '0;
                    end
                    else if (col_last)
                    begin
                        step.nxt_ctx.col = '0;
                        step.nxt_ctx.row = row_inc;
                    end
                    else
                    begin
                        step.nxt_ctx.col = col_inc;
                    end
                end
            end

            default:
            begin
                // unused encoding, fall back to waiting for a header
                step.active        = 1'b1;
                step.nxt_ctx.state = IDLE;
                step.nxt_ctx.col   = '0;
                step.nxt_ctx.row   = '0;
            end
        endcase
    end

endmodule

//--- src/frame_ctx_regs.sv
`timescale 1ns/1ps
`include "border_crop_config.svh"

module frame_ctx_regs
    import border_crop_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               upd_en,
    input  logic [`TAG_W-1:0]  upd_tag,
    input  frame_ctx_t         upd_ctx,
    output frame_ctx_t         ctx [`NUM_STREAMS]
);

    // waiting for a header with all counters at zero
    localparam frame_ctx_t CTX_IDLE = '{
        state:  IDLE,
        col:    '0,
        row:    '0,
        width:  '0,
        height: '0
    };

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < `NUM_STREAMS; i++)
            begin
                ctx[i] <= CTX_IDLE;
            end
        end
        else if (upd_en)
        begin
            // only the stream served this cycle moves
            ctx[upd_tag] <= upd_ctx;
        end
    end

endmodule

//--- src/stream_arbiter.sv
`timescale 1ns/1ps
`include "border_crop_config.svh"

module stream_arbiter
    import border_crop_pkg::*;
(
    input  crop_step_t               steps       [`NUM_STREAMS],
    input  logic [`PEL_W-1:0]        in_pel_data [`NUM_STREAMS],
    input  logic [`SIZE_W-1:0]       height_data [`NUM_STREAMS],
    input  logic [`SIZE_W-1:0]       width_data  [`NUM_STREAMS],
    output logic [`NUM_STREAMS-1:0]  in_pel_read,
    output logic [`NUM_STREAMS-1:0]  height_read,
    output logic [`NUM_STREAMS-1:0]  width_read,
    output logic                     out_write,
    output out_pel_t                 out_pel,
    output logic                     upd_en,
    output logic [`TAG_W-1:0]        upd_tag,
    output frame_ctx_t               upd_ctx
);

    logic [`TAG_W-1:0] sel;
    logic              found;
    crop_step_t        chosen;

    // fixed priority, lowest stream number that can act wins
    always_comb
    begin
        sel   = '0;
        found = 1'b0;
        for (int i = 0; i < `NUM_STREAMS; i++)
        begin
            if (!found && steps[i].active)
            begin
                found = 1'b1;
                sel   = `TAG_W'(i);
            end
        end
    end

    assign chosen    = steps[sel];
    assign upd_en    = found;
    assign upd_tag   = sel;
    assign out_write = found && chosen.wr;
    assign out_pel   = '{tag: sel, pel: in_pel_data[sel]};

    // header words only reach the context here
    always_comb
    begin
        upd_ctx = chosen.nxt_ctx;
        if (chosen.rd_hdr)
        begin
            upd_ctx.height = height_data[sel];
            upd_ctx.width  = width_data[sel];
        end
    end

    // strobes go back to the selected stream only
    always_comb
    begin
        in_pel_read = '0;
        height_read = '0;
        width_read  = '0;
        if (found)
        begin
            in_pel_read[sel] = chosen.rd_pel;
            height_read[sel] = chosen.rd_hdr;
            width_read[sel]  = chosen.rd_hdr;
        end
    end

endmodule

//--- test/border_crop_tb_ref.svh
`ifndef BORDER_CROP_TB_REF_SVH
`define BORDER_CROP_TB_REF_SVH

typedef logic [`PEL_W-1:0] pel_list_t [$];

// rows DROP_ROWS up to h-1 of a raster order frame, in order
function automatic pel_list_t crop_ref(input int h, input int w, input pel_list_t pels);
    pel_list_t kept;
    kept = {};
    for (int r = `DROP_ROWS; r < h; r++)
    begin
        for (int c = 0; c < w; c++)
        begin
            kept.push_back(pels[r * w + c]);
        end
    end
    return kept;
endfunction

// queue one frame on stream s and record what must come out
task automatic load_frame(input int s, input int h, input int w);
    pel_list_t pels;
    pel_list_t kept;
    pels = {};
    for (int i = 0; i < h * w; i++)
    begin
        pels.push_back(`PEL_W'($random(seed)));
    end
    kept = crop_ref(h, w, pels);
    hgt_q[s].push_back(`SIZE_W'(h));
    wid_q[s].push_back(`SIZE_W'(w));
    foreach (pels[i])
    begin
        pel_q[s].push_back(pels[i]);
    end
    foreach (kept[i])
    begin
        exp_q[s].push_back(kept[i]);
    end
    ref_cnt[s] += kept.size();
endtask

// height DROP_ROWS+1 to 20, width 1 to 12
task automatic random_frame(input int s);
    int h;
    int w;
    h = `DROP_ROWS + 1 + int'($unsigned($random(seed)) % (20 - `DROP_ROWS));
    w = 1 + int'($unsigned($random(seed)) % 12);
    load_frame(s, h, w);
endtask

`endif

//--- test/border_crop_tb.sv
`timescale 1ns/1ps
`include "border_crop_config.svh"

module border_crop_tb
    import border_crop_pkg::*;
();

    localparam int DONE_LIMIT = 20000;

    logic                     clk = 1'b0;
    logic                     rst = 1'b1;
    logic [`NUM_STREAMS-1:0]  in_pel_empty = '1;
    logic [`PEL_W-1:0]        in_pel_data  [`NUM_STREAMS] = '{default: '0};
    logic [`NUM_STREAMS-1:0]  in_pel_read;
    logic [`NUM_STREAMS-1:0]  height_empty = '1;
    logic [`SIZE_W-1:0]       height_data  [`NUM_STREAMS] = '{default: '0};
    logic [`NUM_STREAMS-1:0]  height_read;
    logic [`NUM_STREAMS-1:0]  width_empty = '1;
    logic [`SIZE_W-1:0]       width_data   [`NUM_STREAMS] = '{default: '0};
    logic [`NUM_STREAMS-1:0]  width_read;
    logic [`NUM_STREAMS-1:0]  out_full = '0;
    logic                     out_write;
    out_pel_t                 out_pel;

    // the front word of each input queue is what the DUT sees
    logic [`PEL_W-1:0]   pel_q [`NUM_STREAMS][$];
    logic [`SIZE_W-1:0]  hgt_q [`NUM_STREAMS][$];
    logic [`SIZE_W-1:0]  wid_q [`NUM_STREAMS][$];
    logic [`PEL_W-1:0]   exp_q [`NUM_STREAMS][$];
    int                  ref_cnt [`NUM_STREAMS] = '{default: 0};
    int                  out_cnt [`NUM_STREAMS] = '{default: 0};
    int                  seed   = 72;
    logic                gap_on = 1'b0;
    logic                bp_on  = 1'b0;

    task automatic stop_with_failure();
        $display("test failed");
        $fatal(1);
    endtask

    task automatic report_error(input string msg);
        $display("[FAIL] %0t: %s", $time, msg);
        stop_with_failure();
    endtask

    task automatic timeout_abort(input string what);
        $display("timeout at %0t while waiting for %s", $time, what);
        stop_with_failure();
    endtask

    // true about once in n calls
    function automatic logic chance(input int n);
        return ($unsigned($random(seed)) % n) == 0;
    endfunction

    `include "border_crop_tb_ref.svh"

    border_crop_top i_border_crop_top (
        .clk          (clk),
        .rst          (rst),
        .in_pel_empty (in_pel_empty),
        .in_pel_data  (in_pel_data),
        .in_pel_read  (in_pel_read),
        .height_empty (height_empty),
        .height_data  (height_data),
        .height_read  (height_read),
        .width_empty  (width_empty),
        .width_data   (width_data),
        .width_read   (width_read),
        .out_full     (out_full),
        .out_write    (out_write),
        .out_pel      (out_pel)
    );

    initial
    begin
        forever
        begin
            #4 clk = ~clk;
        end
    end

    // FIFO models pop on a strobe and then show the new front
    always @(posedge clk)
    begin
        for (int s = 0; s < `NUM_STREAMS; s++)
        begin
            if (in_pel_read[s] && pel_q[s].size() > 0)
            begin
                pel_q[s].delete(0);
            end
            if (height_read[s] && hgt_q[s].size() > 0)
            begin
                hgt_q[s].delete(0);
            end
            if (width_read[s] && wid_q[s].size() > 0)
            begin
                wid_q[s].delete(0);
            end
            in_pel_empty[s] <= (pel_q[s].size() == 0) || (gap_on && chance(4));
            in_pel_data[s]  <= (pel_q[s].size() > 0) ? pel_q[s][0] : '0;
            height_empty[s] <= (hgt_q[s].size() == 0) || (gap_on && chance(4));
            height_data[s]  <= (hgt_q[s].size() > 0) ? hgt_q[s][0] : '0;
            width_empty[s]  <= (wid_q[s].size() == 0) || (gap_on && chance(4));
            width_data[s]   <= (wid_q[s].size() > 0) ? wid_q[s][0] : '0;
            out_full[s]     <= bp_on && chance(3);
        end
    end

    // protocol checks and pixel comparison
    always @(posedge clk)
    begin
        logic [`NUM_STREAMS-1:0] any_read;
        logic [`PEL_W-1:0]       exp_pel;
        int                      tag;
        if (!rst)
        begin
            any_read = in_pel_read | height_read | width_read;
            assert ($countones(any_read) <= 1)
            else report_error("read strobes active on more than one stream");
            for (int s = 0; s < `NUM_STREAMS; s++)
            begin
                assert (!(in_pel_read[s] && in_pel_empty[s]))
                else report_error($sformatf("stream %0d pixel read while empty", s));
                assert (!(height_read[s] && height_empty[s]) && height_read[s] == width_read[s])
                else report_error($sformatf("stream %0d bad header read", s));
                assert (!(width_read[s] && width_empty[s]))
                else report_error($sformatf("stream %0d width read while empty", s));
            end
            if (out_write)
            begin
                tag = int'(out_pel.tag);
                assert (in_pel_read[tag])
                else report_error($sformatf("write on stream %0d without pixel read", tag));
                assert (!out_full[tag])
                else report_error($sformatf("write on stream %0d while full", tag));
                assert (exp_q[tag].size() > 0)
                else report_error($sformatf("extra pixel on stream %0d", tag));
                exp_pel = exp_q[tag].pop_front();
                assert (out_pel.pel == exp_pel)
                else report_error($sformatf("stream %0d pixel %0d is %h, expected %h",
                                            tag, out_cnt[tag], out_pel.pel, exp_pel));
                out_cnt[tag]++;
            end
        end
    end

    task automatic wait_stream_done(input int s);
        int cycles;
        cycles = 0;
        while (out_cnt[s] < ref_cnt[s])
        begin
            @(negedge clk);
            cycles++;
            if (cycles > DONE_LIMIT)
            begin
                timeout_abort($sformatf("stream %0d output, %0d of %0d pixels seen",
                                        s, out_cnt[s], ref_cnt[s]));
            end
        end
    endtask

    task automatic wait_inputs_drained();
        int cycles;
        int left;
        cycles = 0;
        left   = 1;
        while (left > 0)
        begin
            @(negedge clk);
            left = 0;
            for (int s = 0; s < `NUM_STREAMS; s++)
            begin
                left += pel_q[s].size() + hgt_q[s].size() + wid_q[s].size();
            end
            cycles++;
            if (cycles > DONE_LIMIT)
            begin
                timeout_abort($sformatf("input FIFOs to drain, %0d words left", left));
            end
        end
    endtask

    initial
    begin
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        // no strobe may move while nothing is queued
        repeat (20)
        begin
            @(negedge clk);
            assert (in_pel_read == '0 && height_read == '0 && width_read == '0 && !out_write)
            else report_error("strobe active while all inputs are empty");
        end

        // single stream without gaps and with the output always free
        for (int f = 0; f < 3; f++)
        begin
            random_frame(0);
        end
        wait_stream_done(0);

        // both streams with input gaps and random back-pressure
        gap_on = 1'b1;
        bp_on  = 1'b1;
        for (int f = 0; f < 4; f++)
        begin
            random_frame(0);
            random_frame(1);
        end
        for (int s = 0; s < `NUM_STREAMS; s++)
        begin
            wait_stream_done(s);
        end
        wait_inputs_drained();
        gap_on = 1'b0;
        bp_on  = 1'b0;

        // quiet tail so a late extra write would still be caught
        repeat (10) @(negedge clk);
        $display("test passed");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+src
+incdir+test
src/border_crop_pkg.sv
src/crop_step.sv
src/stream_arbiter.sv
src/frame_ctx_regs.sv
src/border_crop_top.sv
test/border_crop_tb.sv
